//--- hdl/gfx_pkg.sv
// gfx_pkg
// Shared opcodes, command field positions, frame geometry and vector
// types for the triangle rasterizer.

`default_nettype none

package gfx_pkg;

    // frame geometry, two buffers of FB_WORDS each
    localparam int FB_WIDTH  = 128;
    localparam int FB_HEIGHT = 128;
    localparam int FB_WORDS  = FB_WIDTH * FB_HEIGHT;

    // command word fields
    localparam int OP_POS        = 24;
    localparam int OP_SIZE       = 8;
    localparam int COORD_W       = 12;
    localparam int RGB_W         = 12;
    localparam int SWAP_WAIT_BIT = 0;

    localparam logic [3:0] ALPHA_OPAQUE  = 4'hF;
    localparam logic [3:0] VRAM_MASK_ALL = 4'hF;

    typedef logic signed [COORD_W-1:0] coord_t;
    typedef logic [31:0]               vram_addr_t;
    typedef logic [15:0]               pixel_t;
    typedef logic signed [31:0]        edge_t;

    typedef enum logic [OP_SIZE-1:0] {
        OP_SET_X0 = 8'h00,
        OP_SET_Y0 = 8'h01,
        OP_SET_X1 = 8'h02,
        OP_SET_Y1 = 8'h03,
        OP_SET_X2 = 8'h04,
        OP_SET_Y2 = 8'h05,
        OP_CLEAR  = 8'h06,
        OP_DRAW   = 8'h07,
        OP_SWAP   = 8'h08
    } opcode_t;

endpackage

`default_nettype wire

//--- hdl/pix_wr_if.sv
// pix_wr_if
// One pixel write request from an engine to the VRAM writer.

`default_nettype none

interface pix_wr_if
    import gfx_pkg::*;
();
    // req and done are single-cycle pulses, addr/data held until done
    logic       req;
    vram_addr_t addr;
    pixel_t     data;
    logic       done;

    modport engine (output req, output addr, output data, input done);
    modport port   (input req, input addr, input data, output done);

endinterface

`default_nettype wire

//--- hdl/tri_if.sv
// tri_if
// Triangle setup and draw handshake between the command registers
// and the rasterizer.

`default_nettype none

interface tri_if
    import gfx_pkg::*;
();
    coord_t           x0, y0;
    coord_t           x1, y1;
    coord_t           x2, y2;
    logic [RGB_W-1:0] color;
    vram_addr_t       back_base;
    logic             start;
    logic             busy;

    modport source (output x0, y0, x1, y1, x2, y2, output color, output back_base,
                    output start, input busy);
    modport sink   (input x0, y0, x1, y1, x2, y2, input color, input back_base,
                    input start, output busy);

endinterface

`default_nettype wire

//--- hdl/cmd_regs.sv
// cmd_regs
// Command stream decoder. Holds the vertices and the front/back buffer
// addresses, starts the clear and draw engines and runs the buffer swap.

`default_nettype none

module cmd_regs
    import gfx_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset_i,

    input  wire logic        cmd_valid_i,
    output      logic        cmd_ready_o,
    input  wire logic [31:0] cmd_data_i,

    input  wire logic        vsync_i,
    output      logic        swap_o,
    output      vram_addr_t  front_addr_o,

    output      logic        clear_start_o,
    output      pixel_t      clear_color_o,
    output      vram_addr_t  back_base_o,
    input  wire logic        clear_busy_i,

    tri_if.source            tri_bus
);

    typedef enum logic [1:0] {CS_IDLE, CS_START, CS_BUSY, CS_VSYNC} cstate_t;

    cstate_t    state;
    opcode_t    op;
    logic       accept;
    logic       do_swap;
    vram_addr_t front_q, back_q;

    assign op          = opcode_t'(cmd_data_i[OP_POS +: OP_SIZE]);
    assign cmd_ready_o = (state == CS_IDLE);
    assign accept      = cmd_valid_i && cmd_ready_o;

    // immediate swap or the deferred one once vsync arrives
    assign do_swap = (accept && op == OP_SWAP && !cmd_data_i[SWAP_WAIT_BIT])
                  || (state == CS_VSYNC && vsync_i);

    assign front_addr_o      = front_q;
    assign back_base_o       = back_q;
    assign tri_bus.back_base = back_q;

    always_ff @(posedge clk) begin
        swap_o        <= 1'b0;
        clear_start_o <= 1'b0;
        tri_bus.start <= 1'b0;

        case (state)
            CS_IDLE: begin
                if (accept) begin
                    case (op)
                        OP_SET_X0: tri_bus.x0 <= coord_t'(cmd_data_i[COORD_W-1:0]);
                        OP_SET_Y0: tri_bus.y0 <= coord_t'(cmd_data_i[COORD_W-1:0]);
                        OP_SET_X1: tri_bus.x1 <= coord_t'(cmd_data_i[COORD_W-1:0]);
                        OP_SET_Y1: tri_bus.y1 <= coord_t'(cmd_data_i[COORD_W-1:0]);
                        OP_SET_X2: tri_bus.x2 <= coord_t'(cmd_data_i[COORD_W-1:0]);
                        OP_SET_Y2: tri_bus.y2 <= coord_t'(cmd_data_i[COORD_W-1:0]);
                        OP_CLEAR: begin
                            clear_color_o <= cmd_data_i[15:0];
                            clear_start_o <= 1'b1;
                            state         <= CS_START;
                        end
                        OP_DRAW: begin
                            tri_bus.color <= cmd_data_i[RGB_W-1:0];
                            tri_bus.start <= 1'b1;
                            state         <= CS_START;
                        end
                        OP_SWAP: begin
                            if (cmd_data_i[SWAP_WAIT_BIT])
                                state <= CS_VSYNC;
                        end
                        default: ;
                    endcase
                end
            end

            // engine raises busy one cycle after its start pulse
            CS_START: state <= CS_BUSY;

            CS_BUSY: begin
                if (!clear_busy_i && !tri_bus.busy)
                    state <= CS_IDLE;
            end

            CS_VSYNC: begin
                if (vsync_i)
                    state <= CS_IDLE;
            end

            default: state <= CS_IDLE;
        endcase

        if (do_swap) begin
            front_q <= back_q;
            back_q  <= front_q;
            swap_o  <= 1'b1;
        end

        if (reset_i) begin
            state         <= CS_IDLE;
            swap_o        <= 1'b0;
            clear_start_o <= 1'b0;
            tri_bus.start <= 1'b0;
            front_q       <= '0;
            back_q        <= vram_addr_t'(FB_WORDS);
        end
    end

    // one engine at a time
    assert property (@(posedge clk) disable iff (reset_i)
        !(clear_start_o && tri_bus.start))
        else $error("cmd_regs: both engines started together");

endmodule

`default_nettype wire

//--- hdl/clear_engine.sv
// clear_engine
// Fills one frame buffer with a single color, one word per request.

`default_nettype none

module clear_engine
    import gfx_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       start_i,
    input  wire pixel_t     color_i,
    input  wire vram_addr_t base_i,
    output      logic       busy_o,
    pix_wr_if.engine        wr
);

    vram_addr_t base_q;
    logic       last_word;

    assign last_word = (wr.addr == base_q + vram_addr_t'(FB_WORDS - 1));

    always_ff @(posedge clk) begin
        wr.req <= 1'b0;

        if (!busy_o) begin
            if (start_i) begin
                base_q  <= base_i;
                wr.addr <= base_i;
                wr.data <= color_i;
                wr.req  <= 1'b1;
                busy_o  <= 1'b1;
            end
        end else if (wr.done) begin
            if (last_word) begin
                busy_o <= 1'b0;
            end else begin
                wr.addr <= wr.addr + vram_addr_t'(1);
                wr.req  <= 1'b1;
            end
        end

        if (reset_i) begin
            busy_o <= 1'b0;
            wr.req <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (reset_i)
        busy_o |-> (wr.addr >= base_q && wr.addr < base_q + vram_addr_t'(FB_WORDS)))
        else $error("clear_engine: address left the target buffer");

endmodule

`default_nettype wire

//--- hdl/raster_engine.sv
// raster_engine
// Flat triangle rasterizer. Scans the frame-clipped bounding box and
// tests three integer edge functions per pixel on one shared multiplier.

`default_nettype none

module raster_engine
    import gfx_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset_i,
    tri_if.sink       tri_bus,
    pix_wr_if.engine  wr
);

    typedef enum logic [2:0] {
        RS_IDLE, RS_SETUP, RS_MUL, RS_TEST, RS_WRITE, RS_ADVANCE
    } rstate_t;

    rstate_t    state;
    coord_t     min_x, min_y, max_x, max_y;
    coord_t     lo_x, lo_y, hi_x, hi_y;
    coord_t     x, y;
    logic [2:0] step;
    edge_t      mul_a, mul_b, mul_z;
    edge_t      op_a, op_b;
    edge_t      t0, w0, w1, w2;

    function automatic coord_t min3(input coord_t a, input coord_t b, input coord_t c);
        coord_t m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic coord_t max3(input coord_t a, input coord_t b, input coord_t c);
        coord_t m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    // the single multiplier, operands registered by the FSM
    assign mul_z = mul_a * mul_b;

    always_comb begin
        lo_x = (min_x < 0) ? coord_t'(0) : min_x;
        lo_y = (min_y < 0) ? coord_t'(0) : min_y;
        hi_x = (max_x > FB_WIDTH - 1) ? coord_t'(FB_WIDTH - 1) : max_x;
        hi_y = (max_y > FB_HEIGHT - 1) ? coord_t'(FB_HEIGHT - 1) : max_y;
    end

    // w = (px - ax) * (by - ay) - (py - ay) * (bx - ax), edges v1v2, v2v0, v0v1
    always_comb begin
        op_a = '0;
        op_b = '0;
        case (step)
            3'd0: begin
                op_a = edge_t'(x) - edge_t'(tri_bus.x1);
                op_b = edge_t'(tri_bus.y2) - edge_t'(tri_bus.y1);
            end
            3'd1: begin
                op_a = edge_t'(y) - edge_t'(tri_bus.y1);
                op_b = edge_t'(tri_bus.x2) - edge_t'(tri_bus.x1);
            end
            3'd2: begin
                op_a = edge_t'(x) - edge_t'(tri_bus.x2);
                op_b = edge_t'(tri_bus.y0) - edge_t'(tri_bus.y2);
            end
            3'd3: begin
                op_a = edge_t'(y) - edge_t'(tri_bus.y2);
                op_b = edge_t'(tri_bus.x0) - edge_t'(tri_bus.x2);
            end
            3'd4: begin
                op_a = edge_t'(x) - edge_t'(tri_bus.x0);
                op_b = edge_t'(tri_bus.y1) - edge_t'(tri_bus.y0);
            end
            3'd5: begin
                op_a = edge_t'(y) - edge_t'(tri_bus.y0);
                op_b = edge_t'(tri_bus.x1) - edge_t'(tri_bus.x0);
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        wr.req <= 1'b0;

        case (state)
            RS_IDLE: begin
                if (tri_bus.start) begin
                    min_x        <= min3(tri_bus.x0, tri_bus.x1, tri_bus.x2);
                    min_y        <= min3(tri_bus.y0, tri_bus.y1, tri_bus.y2);
                    max_x        <= max3(tri_bus.x0, tri_bus.x1, tri_bus.x2);
                    max_y        <= max3(tri_bus.y0, tri_bus.y1, tri_bus.y2);
                    tri_bus.busy <= 1'b1;
                    state        <= RS_SETUP;
                end
            end

            RS_SETUP: begin
                min_x <= lo_x;
                min_y <= lo_y;
                max_x <= hi_x;
                max_y <= hi_y;
                x     <= lo_x;
                y     <= lo_y;
                step  <= '0;
                // box entirely off screen
                if (lo_x > hi_x || lo_y > hi_y) begin
                    tri_bus.busy <= 1'b0;
                    state        <= RS_IDLE;
                end else begin
                    state <= RS_MUL;
                end
            end

            RS_MUL: begin
                mul_a <= op_a;
                mul_b <= op_b;
                case (step)
                    3'd1, 3'd3, 3'd5: t0 <= mul_z;
                    3'd2: w0 <= t0 - mul_z;
                    3'd4: w1 <= t0 - mul_z;
                    3'd6: w2 <= t0 - mul_z;
                    default: ;
                endcase
                step <= step + 3'd1;
                if (step == 3'd6)
                    state <= RS_TEST;
            end

            RS_TEST: begin
                if (w0 >= 0 && w1 >= 0 && w2 >= 0) begin
                    wr.addr <= tri_bus.back_base + vram_addr_t'(y) * vram_addr_t'(FB_WIDTH)
                             + vram_addr_t'(x);
                    wr.data <= {ALPHA_OPAQUE, tri_bus.color};
                    wr.req  <= 1'b1;
                    state   <= RS_WRITE;
                end else begin
                    state <= RS_ADVANCE;
                end
            end

            RS_WRITE: begin
                if (wr.done)
                    state <= RS_ADVANCE;
            end

            RS_ADVANCE: begin
                step <= '0;
                if (x < max_x) begin
                    x     <= x + coord_t'(1);
                    state <= RS_MUL;
                end else if (y < max_y) begin
                    x     <= min_x;
                    y     <= y + coord_t'(1);
                    state <= RS_MUL;
                end else begin
                    tri_bus.busy <= 1'b0;
                    state        <= RS_IDLE;
                end
            end

            default: state <= RS_IDLE;
        endcase

        if (reset_i) begin
            state        <= RS_IDLE;
            tri_bus.busy <= 1'b0;
            wr.req       <= 1'b0;
            step         <= '0;
        end
    end

    assert property (@(posedge clk) disable iff (reset_i)
        wr.req |-> (x >= min_x && x <= max_x && y >= min_y && y <= max_y
                    && min_x >= 0 && max_x < FB_WIDTH && min_y >= 0 && max_y < FB_HEIGHT))
        else $error("raster_engine: write outside the clipped box");

endmodule

`default_nettype wire

//--- hdl/vram_writer.sv
// vram_writer
// VRAM bus master shared by the clear and raster engines. Holds select
// until ack and returns done to whichever engine asked.

`default_nettype none

module vram_writer
    import gfx_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset_i,
    pix_wr_if.port    clr,
    pix_wr_if.port    ras,
    input  wire logic vram_ack_i,
    output      logic vram_sel_o,
    output      logic vram_wr_o,
    output      logic [3:0] vram_mask_o,
    output      vram_addr_t vram_addr_o,
    output      pixel_t     vram_data_out_o
);

    logic owner_ras;

    always_ff @(posedge clk) begin
        clr.done <= 1'b0;
        ras.done <= 1'b0;

        if (vram_sel_o) begin
            if (vram_ack_i) begin
                vram_sel_o <= 1'b0;
                vram_wr_o  <= 1'b0;
                if (owner_ras)
                    ras.done <= 1'b1;
                else
                    clr.done <= 1'b1;
            end
        end else if (clr.req || ras.req) begin
            owner_ras       <= ras.req;
            vram_addr_o     <= ras.req ? ras.addr : clr.addr;
            vram_data_out_o <= ras.req ? ras.data : clr.data;
            vram_mask_o     <= VRAM_MASK_ALL;
            vram_sel_o      <= 1'b1;
            vram_wr_o       <= 1'b1;
        end

        if (reset_i) begin
            vram_sel_o  <= 1'b0;
            vram_wr_o   <= 1'b0;
            vram_mask_o <= '0;
            clr.done    <= 1'b0;
            ras.done    <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (reset_i) !(clr.req && ras.req))
        else $error("vram_writer: both engines requested at once");

    assert property (@(posedge clk) disable iff (reset_i)
        (vram_sel_o && !vram_ack_i) |=> vram_sel_o)
        else $error("vram_writer: select dropped before ack");

endmodule

`default_nettype wire

//--- hdl/gfx_top.sv
// gfx_top
// Triangle rasterizer top level: command registers, clear and raster
// engines and the shared VRAM writer.

`default_nettype none

module gfx_top
    import gfx_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset_i,

    // command stream
    input  wire logic        cmd_valid_i,
    output      logic        cmd_ready_o,
    input  wire logic [31:0] cmd_data_i,

    // VRAM write port
    input  wire logic        vram_ack_i,
    output      logic        vram_sel_o,
    output      logic        vram_wr_o,
    output      logic [3:0]  vram_mask_o,
    output      vram_addr_t  vram_addr_o,
    output      pixel_t      vram_data_out_o,

    input  wire logic        vsync_i,
    output      logic        swap_o,
    output      vram_addr_t  front_addr_o
);

    logic       clear_start;
    logic       clear_busy;
    pixel_t     clear_color;
    vram_addr_t back_base;

    pix_wr_if clr_wr ();
    pix_wr_if ras_wr ();
    tri_if    tri_bus ();

    cmd_regs u_cmd_regs (
        .clk           (clk),
        .reset_i       (reset_i),
        .cmd_valid_i   (cmd_valid_i),
        .cmd_ready_o   (cmd_ready_o),
        .cmd_data_i    (cmd_data_i),
        .vsync_i       (vsync_i),
        .swap_o        (swap_o),
        .front_addr_o  (front_addr_o),
        .clear_start_o (clear_start),
        .clear_color_o (clear_color),
        .back_base_o   (back_base),
        .clear_busy_i  (clear_busy),
        .tri_bus       (tri_bus.source)
    );

    clear_engine u_clear_engine (
        .clk     (clk),
        .reset_i (reset_i),
        .start_i (clear_start),
        .color_i (clear_color),
        .base_i  (back_base),
        .busy_o  (clear_busy),
        .wr      (clr_wr.engine)
    );

    raster_engine u_raster_engine (
        .clk     (clk),
        .reset_i (reset_i),
        .tri_bus (tri_bus.sink),
        .wr      (ras_wr.engine)
    );

    vram_writer u_vram_writer (
        .clk             (clk),
        .reset_i         (reset_i),
        .clr             (clr_wr.port),
        .ras             (ras_wr.port),
        .vram_ack_i      (vram_ack_i),
        .vram_sel_o      (vram_sel_o),
        .vram_wr_o       (vram_wr_o),
        .vram_mask_o     (vram_mask_o),
        .vram_addr_o     (vram_addr_o),
        .vram_data_out_o (vram_data_out_o)
    );

endmodule

`default_nettype wire

//--- sim/vram_model.sv
// vram_model
// VRAM slave for simulation. Acks each select after a random 1 to 3 cycle
// delay, stores the written words and flags writes outside both buffers.

`default_nettype none

module vram_model
    import gfx_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       sel_i,
    input  wire logic       wr_i,
    input  wire logic [3:0] mask_i,
    input  wire vram_addr_t addr_i,
    input  wire pixel_t     data_i,
    output      logic       ack_o,
    output      logic       bad_write_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_WORDS = 2 * FB_WORDS;

    pixel_t mem [MEM_WORDS];
    integer seed;
    logic   pending;
    int     delay;

    // fill pattern covers every address bit
    initial begin
        seed  = 91506;
        ack_o = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = pixel_t'(i) ^ 16'hC35A;
    end

    always @(posedge clk) begin
        ack_o <= 1'b0;
        if (reset_i) begin
            pending     <= 1'b0;
            bad_write_o <= 1'b0;
        end else if (sel_i && !ack_o) begin
            if (!pending) begin
                assert (addr_i < vram_addr_t'(MEM_WORDS)) else bad_write_o <= 1'b1;
                assert (wr_i && mask_i == 4'hF) else bad_write_o <= 1'b1;
                pending <= 1'b1;
                delay   <= {$random(seed)} % 3;
            end else if (delay == 0) begin
                ack_o   <= 1'b1;
                pending <= 1'b0;
                if (addr_i < vram_addr_t'(MEM_WORDS))
                    mem[addr_i[14:0]] <= data_i;
            end else begin
                delay <= delay - 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_gfx.sv
// tb_gfx
// Testbench for the triangle rasterizer. Covers clear, draw, clipped draw
// and both swap modes, checked against a shadow copy of VRAM.

`default_nettype none

module tb_gfx
    import gfx_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_WORDS   = 2 * FB_WORDS;
    localparam int CMD_TIMEOUT = 100;
    localparam int RUN_TIMEOUT = 600000;
    localparam int VSYNC_HOLD  = 20;

    logic        clk;
    logic        reset;
    logic        cmd_valid;
    logic        cmd_ready;
    logic [31:0] cmd_data;
    logic        vram_ack;
    logic        vram_sel;
    logic        vram_wr;
    logic [3:0]  vram_mask;
    vram_addr_t  vram_addr;
    pixel_t      vram_data;
    logic        vsync;
    logic        swap;
    vram_addr_t  front_addr;
    logic        bad_write;

    pixel_t      shadow [MEM_WORDS];
    vram_addr_t  front_exp;
    vram_addr_t  back_exp;
    vram_addr_t  old_back;
    int          vx [3];
    int          vy [3];
    int          swap_count;
    int          swaps_before;

    gfx_top UUT (
        .clk             (clk),
        .reset_i         (reset),
        .cmd_valid_i     (cmd_valid),
        .cmd_ready_o     (cmd_ready),
        .cmd_data_i      (cmd_data),
        .vram_ack_i      (vram_ack),
        .vram_sel_o      (vram_sel),
        .vram_wr_o       (vram_wr),
        .vram_mask_o     (vram_mask),
        .vram_addr_o     (vram_addr),
        .vram_data_out_o (vram_data),
        .vsync_i         (vsync),
        .swap_o          (swap),
        .front_addr_o    (front_addr)
    );

    vram_model vram (
        .clk         (clk),
        .reset_i     (reset),
        .sel_i       (vram_sel),
        .wr_i        (vram_wr),
        .mask_i      (vram_mask),
        .addr_i      (vram_addr),
        .data_i      (vram_data),
        .ack_o       (vram_ack),
        .bad_write_o (bad_write)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        if (reset)
            swap_count <= 0;
        else if (swap)
            swap_count <= swap_count + 1;
    end

    task automatic stop_on_failure(input string line);
        $display("CHECKS FAILED");
        $display("%s", line);
        $fatal(1, "simulation stopped at the first failure");
    endtask

    function automatic string mismatch_text(input string msg);
        return $sformatf("FAILED %0t: %s", $time, msg);
    endfunction

    assert property (@(posedge clk) disable iff (reset) !bad_write)
        else stop_on_failure("VRAM write outside both frame buffers or without full mask");

    assert property (@(posedge clk) disable iff (reset) swap |=> !swap)
        else stop_on_failure(mismatch_text("swap_o high for more than one cycle"));

    // no command is taken during a VRAM access
    assert property (@(posedge clk) disable iff (reset) vram_sel |-> !cmd_ready)
        else stop_on_failure(mismatch_text("cmd_ready_o high during a VRAM access"));

    function automatic logic [31:0] cmd_word(input opcode_t op, input logic [23:0] arg);
        return {op, arg};
    endfunction

    // edge function of edge a->b at pixel p
    function automatic int edge_value(input int ax, input int ay, input int bx,
                                      input int by, input int px, input int py);
        return (px - ax) * (by - ay) - (py - ay) * (bx - ax);
    endfunction

    function automatic logic covers(input int px, input int py);
        return edge_value(vx[1], vy[1], vx[2], vy[2], px, py) >= 0
            && edge_value(vx[2], vy[2], vx[0], vy[0], px, py) >= 0
            && edge_value(vx[0], vy[0], vx[1], vy[1], px, py) >= 0;
    endfunction

    function automatic int smallest(input int a, input int b, input int c);
        int m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic int largest(input int a, input int b, input int c);
        int m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    // called on a rising edge and returns on the edge that took the word
    task automatic send_cmd(input logic [31:0] word);
        int waited;
        waited = 0;
        cmd_valid <= 1'b1;
        cmd_data  <= word;
        @(negedge clk);
        while (!cmd_ready) begin
            if (waited == CMD_TIMEOUT) begin
                stop_on_failure("timeout waiting for cmd_ready_o to take a command");
            end else begin
                waited++;
                @(negedge clk);
            end
        end
        @(posedge clk);
        cmd_valid <= 1'b0;
    endtask

    task automatic wait_ready(input int limit, input string what);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!cmd_ready) begin
            if (waited == limit) begin
                stop_on_failure($sformatf("timeout waiting for %s", what));
            end else begin
                waited++;
                @(negedge clk);
            end
        end
        @(posedge clk);
    endtask

    // returns on the falling edge where swap_o is high
    task automatic wait_swap(input string what);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!swap) begin
            if (waited == CMD_TIMEOUT) begin
                stop_on_failure($sformatf("timeout waiting for swap_o after %s", what));
            end else begin
                waited++;
                @(negedge clk);
            end
        end
    endtask

    task automatic clear_back(input pixel_t color);
        send_cmd(cmd_word(OP_CLEAR, {8'h00, color}));
        wait_ready(RUN_TIMEOUT, "the clear to finish");
        for (int i = 0; i < FB_WORDS; i++)
            shadow[int'(back_exp) + i] = color;
    endtask

    task automatic draw_triangle(input logic [11:0] rgb);
        int lo_x;
        int lo_y;
        int hi_x;
        int hi_y;
        send_cmd(cmd_word(OP_SET_X0, {12'h000, 12'(vx[0])}));
        send_cmd(cmd_word(OP_SET_Y0, {12'h000, 12'(vy[0])}));
        send_cmd(cmd_word(OP_SET_X1, {12'h000, 12'(vx[1])}));
        send_cmd(cmd_word(OP_SET_Y1, {12'h000, 12'(vy[1])}));
        send_cmd(cmd_word(OP_SET_X2, {12'h000, 12'(vx[2])}));
        send_cmd(cmd_word(OP_SET_Y2, {12'h000, 12'(vy[2])}));
        send_cmd(cmd_word(OP_DRAW, {12'h000, rgb}));
        wait_ready(RUN_TIMEOUT, "the draw to finish");
        // bounding box clipped to the frame
        lo_x = smallest(vx[0], vx[1], vx[2]);
        lo_y = smallest(vy[0], vy[1], vy[2]);
        hi_x = largest(vx[0], vx[1], vx[2]);
        hi_y = largest(vy[0], vy[1], vy[2]);
        lo_x = (lo_x < 0) ? 0 : lo_x;
        lo_y = (lo_y < 0) ? 0 : lo_y;
        hi_x = (hi_x > FB_WIDTH - 1) ? FB_WIDTH - 1 : hi_x;
        hi_y = (hi_y > FB_HEIGHT - 1) ? FB_HEIGHT - 1 : hi_y;
        for (int y = lo_y; y <= hi_y; y++) begin
            for (int x = lo_x; x <= hi_x; x++) begin
                if (covers(x, y))
                    shadow[int'(back_exp) + y * FB_WIDTH + x] = {4'hF, rgb};
            end
        end
    endtask

    task automatic check_memory(input string phase);
        for (int i = 0; i < MEM_WORDS; i++) begin
            assert (vram.mem[i] == shadow[i])
                else stop_on_failure(mismatch_text($sformatf("%s: word %0d is %h, expected %h",
                                                             phase, i, vram.mem[i], shadow[i])));
        end
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd_data  = '0;
        vsync     = 1'b0;
        front_exp = '0;
        back_exp  = vram_addr_t'(FB_WORDS);
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < MEM_WORDS; i++)
            shadow[i] = vram.mem[i];

        @(negedge clk);
        assert (cmd_ready && !vram_sel && !swap && front_addr == 0)
            else stop_on_failure(mismatch_text("outputs after reset are wrong"));
        @(posedge clk);

        clear_back(16'h2C4B);
        check_memory("clear");

        vx = '{10, 20, 60};
        vy = '{10, 50, 20};
        draw_triangle(12'h3A7);
        check_memory("draw");

        // vertices off the frame on both sides
        clear_back(16'h0F0F);
        vx = '{-30, 40, 160};
        vy = '{-20, 150, 30};
        draw_triangle(12'hC15);
        check_memory("clipped draw");

        swaps_before = swap_count;
        old_back     = back_exp;
        send_cmd(cmd_word(OP_SWAP, 24'h000000));
        wait_swap("an immediate swap");
        assert (front_addr == old_back)
            else stop_on_failure(mismatch_text("front address after immediate swap"));
        back_exp  = front_exp;
        front_exp = old_back;
        @(posedge clk);
        clear_back(16'h7E81);
        check_memory("clear after swap");
        assert (swap_count == swaps_before + 1)
            else stop_on_failure(mismatch_text("swap_o pulse count after immediate swap"));

        old_back = back_exp;
        send_cmd(cmd_word(OP_SWAP, 24'h000001));
        for (int n = 0; n < VSYNC_HOLD; n++) begin
            @(negedge clk);
            assert (!cmd_ready && !swap && front_addr == front_exp)
                else stop_on_failure(mismatch_text("swap went ahead without vsync"));
        end
        @(posedge clk);
        vsync <= 1'b1;
        wait_swap("vsync");
        assert (front_addr == old_back)
            else stop_on_failure(mismatch_text("front address after vsync swap"));
        @(posedge clk);
        vsync <= 1'b0;
        wait_ready(CMD_TIMEOUT, "ready after the vsync swap");
        assert (swap_count == swaps_before + 2)
            else stop_on_failure(mismatch_text("swap_o pulse count after vsync swap"));

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
hdl/gfx_pkg.sv
hdl/pix_wr_if.sv
hdl/tri_if.sv
hdl/cmd_regs.sv
hdl/clear_engine.sv
hdl/raster_engine.sv
hdl/vram_writer.sv
hdl/gfx_top.sv
sim/vram_model.sv
sim/tb_gfx.sv

//--- Makefile
# Verilator build and run for the triangle rasterizer testbench

VERILATOR ?= verilator
TOP       ?= tb_gfx
FLAGS     ?= -Wno-fatal
OBJ_DIR   ?= obj_dir

SOURCES := $(shell grep -v '^+' all.f)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): all.f $(SOURCES)
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f all.f $(FLAGS)

# exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
